// ==== list.f ====
cmd_pkg.sv
wb_if.sv
uart_rx.sv
uart_tx.sv
word_ram.sv
cmd_exec.sv
pin_bridge_top.sv
tb_pin_bridge_asserts.sv
tb_pin_bridge.sv

// ==== tb_pin_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pin_bridge;

  localparam int frame_clks = 10 * cmd_pkg::clks_per_bit;

  logic                                             sys_clk;
  logic                                             sys_rst_n;
  logic                                             uart_rxd;
  logic [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] in_pins;
  wire                                              uart_txd;
  wire  [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] out_pins;
  wire  [cmd_pkg::n_ports-1:0]                      out_oe;
  wire                                              out_clk;
  wire                                              out_rst;
  wire                                              busy;

  // reference model state
  logic [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] m_pins = '0;
  logic [cmd_pkg::n_ports-1:0]                      m_oe   = '0;
  logic                                             m_clk  = 1'b0;
  logic                                             m_rst  = 1'b0;
  logic [7:0]  m_ureg [8]   = '{default: 8'h00};
  logic [7:0]  m_res  [8]   = '{default: 8'h00};
  logic [15:0] m_mem  [256] = '{default: 16'h0000};

  logic [7:0]  rx_q [$];     // bytes seen on uart_txd
  logic [7:0]  exp_q [$];
  logic [7:0]  unknown_ops [16] = '{8'h00, 8'h0F, 8'h14, 8'h1F, 8'h2B, 8'h3C, 8'h48, 8'h5F,
                                    8'h6A, 8'h7E, 8'h8F, 8'h9A, 8'hA2, 8'hA5, 8'hC3, 8'hFF};
  integer      seed = 32'hb534cb51;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_mark = 0;

  pin_bridge_top dut0 (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .uart_txd  (uart_txd),
    .in_pins   (in_pins),
    .out_pins  (out_pins),
    .out_oe    (out_oe),
    .out_clk   (out_clk),
    .out_rst   (out_rst),
    .busy      (busy)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
    end
  endtask

  // 8N1 frame onto uart_rxd, lsb first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      uart_rxd <= frame[i];
      repeat (cmd_pkg::clks_per_bit - 1) @(posedge sys_clk);
    end
  endtask

  task automatic wait_done(input logic [7:0] c);
    int n;
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (busy !== 1'b1 && n < 8 * cmd_pkg::clks_per_bit);
    if (busy !== 1'b1) begin
      errors++;
      $display("timeout: busy never rose for command %h", c);
    end
    n = 0;
    while (busy !== 1'b0 && n < 40 * frame_clks) begin
      @(negedge sys_clk);
      n++;
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("timeout: busy stayed high for command %h", c);
    end
  endtask

  task automatic wait_bytes(input int count);
    int n;
    n = 0;
    while (rx_q.size() < count && n < 3 * frame_clks) begin
      @(negedge sys_clk);
      n++;
    end
    if (rx_q.size() < count) begin
      errors++;
      $display("timeout: only %0d of %0d reply bytes arrived", rx_q.size(), count);
    end
  endtask

  function automatic bit takes_data(input logic [7:0] c);
    return (c[7:4] == cmd_pkg::grp_pin_wr || c[7:4] == cmd_pkg::grp_ureg_wr) && c[3:0] < 8;
  endfunction

  // expected effect of one command, reply bytes go to exp_q
  task automatic model_cmd(input logic [7:0] c, input logic [7:0] d);
    logic [7:0] a;
    logic [7:0] sum;
    int         i;
    if (c == cmd_pkg::op_mem_wr) begin
      m_mem[m_ureg[2]] = {m_ureg[1], m_ureg[0]};
    end else if (c == cmd_pkg::op_mem_rd) begin
      m_res[1] = m_mem[m_ureg[2]][15:8];
      m_res[0] = m_mem[m_ureg[2]][7:0];
    end else if (c == cmd_pkg::op_burst_rd) begin
      sum = 8'h00;
      for (i = 0; i < cmd_pkg::burst_words; i++) begin
        a = m_ureg[2] + 8'(i);             // wraps at 256
        exp_q.push_back(m_mem[a][7:0]);
        exp_q.push_back(m_mem[a][15:8]);
        sum = sum + m_mem[a][7:0] + m_mem[a][15:8];
      end
      exp_q.push_back(sum);
    end else if (c[3:0] < 8) begin
      case (c[7:4])
        cmd_pkg::grp_ctrl: begin
          if (c[3:0] == 4'h0) m_clk = 1'b1;
          if (c[3:0] == 4'h1) m_clk = 1'b0;
          if (c[3:0] == 4'h2) m_rst = 1'b1;
          if (c[3:0] == 4'h3) m_rst = 1'b0;
        end
        cmd_pkg::grp_pin_rd:  exp_q.push_back(in_pins[c[2:0]]);
        cmd_pkg::grp_pin_wr: begin
          m_pins[c[2:0]] = d;
          m_oe[c[2:0]]   = 1'b1;
        end
        cmd_pkg::grp_ureg_wr: m_ureg[c[2:0]] = d;
        cmd_pkg::grp_res_rd:  exp_q.push_back(m_res[c[2:0]]);
        cmd_pkg::grp_pin_rel: m_oe[c[2:0]] = 1'b0;
        default: ;
      endcase
    end
  endtask

  task automatic run_cmd(input logic [7:0] c, input logic [7:0] d);
    logic [7:0] got;
    send_byte(c);
    if (takes_data(c)) begin
      send_byte(d);
    end
    wait_done(c);
    model_cmd(c, d);
    wait_bytes(exp_q.size());
    while (exp_q.size() > 0) begin
      got = 8'hxx;
      if (rx_q.size() > 0) begin
        got = rx_q.pop_front();
      end
      check(got, exp_q.pop_front(), $sformatf("reply byte to %h", c));
    end
    check(out_pins, m_pins, $sformatf("out_pins after %h", c));
    check(out_oe, m_oe, $sformatf("out_oe after %h", c));
    check(out_clk, m_clk, $sformatf("out_clk after %h", c));
    check(out_rst, m_rst, $sformatf("out_rst after %h", c));
  endtask

  // let the line settle, anything left over is an extra byte
  task automatic end_test(input string name);
    int quiet;
    int n;
    quiet = 0;
    n = 0;
    while (quiet < 12 * cmd_pkg::clks_per_bit && n < 50 * frame_clks) begin
      @(negedge sys_clk);
      n++;
      quiet = (uart_txd === 1'b1) ? quiet + 1 : 0;
    end
    if (quiet < 12 * cmd_pkg::clks_per_bit) begin
      errors++;
      $display("timeout: uart_txd never went quiet after %s", name);
    end
    if (rx_q.size() != 0) begin
      errors++;
      $display("%0d unexpected bytes on uart_txd during %s", rx_q.size(), name);
      rx_q.delete();
    end
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin : txd_monitor
    logic [7:0] b;
    int         i;
    forever begin
      @(negedge sys_clk);
      if (uart_txd === 1'b0) begin
        repeat (cmd_pkg::clks_per_bit / 2) @(negedge sys_clk);   // mid start bit
        for (i = 0; i < 8; i++) begin
          repeat (cmd_pkg::clks_per_bit) @(negedge sys_clk);
          b[i] = uart_txd;
        end
        repeat (cmd_pkg::clks_per_bit) @(negedge sys_clk);
        if (uart_txd !== 1'b1) begin
          errors++;
          $display("framing error on uart_txd at %0t ns", $time);
        end
        rx_q.push_back(b);
      end
    end
  end

  initial begin : main
    logic [31:0] r;
    logic [7:0]  b;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [7:0]  c;
    int          i;
    int          n;
    sys_rst_n = 1'b0;
    uart_rxd  = 1'b1;
    in_pins   = '0;
    repeat (16) @(posedge sys_clk);
    sys_rst_n <= 1'b1;
    @(negedge sys_clk);

    check(busy, 1'b0, "busy after reset");
    check(uart_txd, 1'b1, "uart_txd after reset");
    check(out_pins, '0, "out_pins after reset");
    check(out_oe, '0, "out_oe after reset");
    check({out_clk, out_rst}, 2'b00, "control outputs after reset");
    end_test("reset values");

    for (i = 0; i < 12; i++) begin
      r = next_rand();
      run_cmd(8'h10 | r[1:0], 8'h00);
    end
    end_test("control commands");

    for (i = 0; i < cmd_pkg::n_ports; i++) begin
      r = next_rand();
      n = (i + r[2:0]) % cmd_pkg::n_ports;
      b = r[15:8];
      run_cmd({cmd_pkg::grp_pin_wr, 4'(n)}, b);
      check(out_pins[n], b, $sformatf("out_pins[%0d] after write", n));
      check(out_oe[n], 1'b1, $sformatf("out_oe[%0d] after write", n));
      run_cmd({cmd_pkg::grp_pin_rel, 4'(n)}, 8'h00);
      check(out_oe[n], 1'b0, $sformatf("out_oe[%0d] after release", n));
      check(out_pins[n], b, $sformatf("out_pins[%0d] after release", n));
    end
    end_test("pin write and release");

    for (i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      in_pins <= {next_rand(), next_rand()};
      r = next_rand();
      run_cmd({cmd_pkg::grp_pin_rd, 1'b0, r[2:0]}, 8'h00);
    end
    end_test("pin read");

    for (i = 0; i < 4; i++) begin
      r = next_rand();
      lo = r[7:0];
      hi = r[15:8];
      run_cmd(8'h40, lo);
      run_cmd(8'h41, hi);
      run_cmd(8'h42, r[23:16]);
      run_cmd(cmd_pkg::op_mem_wr, 8'h00);
      run_cmd(8'h40, ~lo);     // must not leak into the read
      run_cmd(8'h41, ~hi);
      run_cmd(cmd_pkg::op_mem_rd, 8'h00);
      run_cmd(8'h50, 8'h00);
      run_cmd(8'h51, 8'h00);
    end
    end_test("word write and read");

    for (i = 0; i < cmd_pkg::burst_words; i++) begin
      r = next_rand();
      run_cmd(8'h40, r[7:0]);
      run_cmd(8'h41, r[15:8]);
      run_cmd(8'h42, 8'hFC + 8'(i));   // crosses 255 -> 0
      run_cmd(cmd_pkg::op_mem_wr, 8'h00);
    end
    run_cmd(8'h42, 8'hFC);
    run_cmd(cmd_pkg::op_burst_rd, 8'h00);
    end_test("burst read");

    for (i = 0; i < 60; i++) begin
      r = next_rand();
      b = r[31:24];
      case (r[2:0])
        3'd0: c = 8'h10 | r[9:8];
        3'd1: begin
          @(posedge sys_clk);
          in_pins <= {next_rand(), next_rand()};
          c = {cmd_pkg::grp_pin_rd, 1'b0, r[10:8]};
        end
        3'd2: c = {cmd_pkg::grp_pin_wr, 1'b0, r[10:8]};
        3'd3: c = {cmd_pkg::grp_ureg_wr, 1'b0, r[10:8]};
        3'd4: c = {cmd_pkg::grp_res_rd, 1'b0, r[10:8]};
        3'd5: c = {cmd_pkg::grp_pin_rel, 1'b0, r[10:8]};
        3'd6: c = r[9] ? cmd_pkg::op_burst_rd : (r[8] ? cmd_pkg::op_mem_rd : cmd_pkg::op_mem_wr);
        default: c = unknown_ops[r[11:8]];
      endcase
      run_cmd(c, b);
    end
    end_test("random mix");

    if (dut0.u_exec.u_protocol_asserts.fail_count != 0) begin
      errors += dut0.u_exec.u_protocol_asserts.fail_count;
      $display("%0d assertion failures in the executor",
               dut0.u_exec.u_protocol_asserts.fail_count);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_pin_bridge_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_protocol_asserts (
  input wire                         sys_clk,
  input wire                         sys_rst_n,
  input wire                         cyc,
  input wire                         stb,
  input wire                         we,
  input wire [cmd_pkg::mem_aw-1:0]   adr,
  input wire [cmd_pkg::mem_dw-1:0]   dat_w,
  input wire                         ack,
  input wire                         tx_start,
  input wire                         tx_busy,
  input wire                         busy
);

  int fail_count = 0;   // read by the testbench at the end

  a_stb_in_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    stb |-> cyc)
    else begin
      $error("stb raised outside a bus cycle");
      fail_count++;
    end

  // request held until the slave answers
  a_req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    (stb && !ack) |=> (stb && cyc && $stable(we) && $stable(adr) && $stable(dat_w)))
    else begin
      $error("wishbone request changed before ack");
      fail_count++;
    end

  a_tx_start_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    tx_start |-> !tx_busy)
    else begin
      $error("tx_start while transmitter busy");
      fail_count++;
    end

  a_idle_after_reset: assert property (@(posedge sys_clk) $rose(sys_rst_n) |-> !busy)
    else begin
      $error("executor busy right after reset");
      fail_count++;
    end

endmodule

bind cmd_exec exec_protocol_asserts u_protocol_asserts (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .cyc       (mem.cyc),
  .stb       (mem.stb),
  .we        (mem.we),
  .adr       (mem.adr),
  .dat_w     (mem.dat_w),
  .ack       (mem.ack),
  .tx_start  (tx_start),
  .tx_busy   (tx_busy),
  .busy      (busy)
);

`default_nettype wire

// ==== pin_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pin_bridge_top (
  input  wire                                              sys_clk,
  input  wire                                              sys_rst_n,
  input  wire                                              uart_rxd,
  output logic                                             uart_txd,
  input  wire  [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] in_pins,
  output logic [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] out_pins,
  output logic [cmd_pkg::n_ports-1:0]                      out_oe,
  output logic                                             out_clk,
  output logic                                             out_rst,
  output logic                                             busy
);

  // byte streams between uart and executor
  logic                       rx_valid;
  logic [cmd_pkg::byte_w-1:0] rx_data;
  logic                       tx_start;
  logic [cmd_pkg::byte_w-1:0] tx_data;
  logic                       tx_busy;

  wb_if wb ();

  uart_rx u_rx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data)
  );

  uart_tx u_tx (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .uart_txd  (uart_txd),
    .tx_busy   (tx_busy)
  );

  cmd_exec u_exec (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .tx_busy   (tx_busy),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .mem       (wb.master),
    .in_pins   (in_pins),
    .out_pins  (out_pins),
    .out_oe    (out_oe),
    .out_clk   (out_clk),
    .out_rst   (out_rst),
    .busy      (busy)
  );

  word_ram u_ram (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .bus       (wb.slave)
  );

endmodule

`default_nettype wire

// ==== cmd_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_exec (
  input  wire                                              sys_clk,
  input  wire                                              sys_rst_n,
  input  wire                                              rx_valid,
  input  wire  [cmd_pkg::byte_w-1:0]                       rx_data,
  input  wire                                              tx_busy,
  output logic                                             tx_start,
  output logic [cmd_pkg::byte_w-1:0]                       tx_data,
  wb_if.master                                             mem,
  input  wire  [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] in_pins,
  output logic [cmd_pkg::n_ports-1:0][cmd_pkg::byte_w-1:0] out_pins,
  output logic [cmd_pkg::n_ports-1:0]                      out_oe,
  output logic                                             out_clk,
  output logic                                             out_rst,
  output logic                                             busy
);

  cmd_pkg::cmd_t                                     cmd;
  logic [2:0]                                        state;
  logic [cmd_pkg::n_uregs-1:0][cmd_pkg::byte_w-1:0]  ureg;      // host written
  logic [cmd_pkg::n_uregs-1:0][cmd_pkg::byte_w-1:0]  res;       // read back by 0x5n
  logic [cmd_pkg::mem_dw-1:0]                        word_buf;
  logic [$clog2(cmd_pkg::burst_words)-1:0]           wcnt;
  logic                                              hi_byte;
  logic [cmd_pkg::byte_w-1:0]                        sum;       // burst checksum
  logic [cmd_pkg::sel_w-1:0]                         sel;
  logic                                              idx_ok;
  logic                                              tx_ready;
  logic [cmd_pkg::byte_w-1:0]                        burst_byte;

  assign sel      = cmd.f.idx[cmd_pkg::sel_w-1:0];
  assign idx_ok   = cmd.f.idx < cmd_pkg::n_ports;   // upper half of index is unknown
  assign tx_ready = !tx_busy && !tx_start;         // tx_busy lags tx_start by a cycle
  assign busy     = state != cmd_pkg::st_idle;

  assign burst_byte = hi_byte ? word_buf[cmd_pkg::mem_dw-1:cmd_pkg::byte_w]
                              : word_buf[cmd_pkg::byte_w-1:0];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state     <= cmd_pkg::st_idle;
      cmd       <= '0;
      ureg      <= '0;
      res       <= '0;
      out_pins  <= '0;
      out_oe    <= '0;
      out_clk   <= 1'b0;
      out_rst   <= 1'b0;
      tx_start  <= 1'b0;
      tx_data   <= '0;
      mem.cyc   <= 1'b0;
      mem.stb   <= 1'b0;
      mem.we    <= 1'b0;
      mem.adr   <= '0;
      mem.dat_w <= '0;
      word_buf  <= '0;
      wcnt      <= '0;
      hi_byte   <= 1'b0;
      sum       <= '0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        cmd_pkg::st_idle: begin
          if (rx_valid) begin
            cmd.raw <= rx_data;
            state   <= cmd_pkg::st_exec;
          end
        end

        cmd_pkg::st_exec: begin
          state <= cmd_pkg::st_idle;     // most commands end here
          case (cmd.f.grp)
            cmd_pkg::grp_ctrl: begin
              case (cmd.f.idx)
                4'h0:    out_clk <= 1'b1;
                4'h1:    out_clk <= 1'b0;
                4'h2:    out_rst <= 1'b1;
                4'h3:    out_rst <= 1'b0;
                default: ;
              endcase
            end
            cmd_pkg::grp_pin_rd, cmd_pkg::grp_res_rd: begin
              if (idx_ok) begin
                state <= cmd_pkg::st_send;
              end
            end
            cmd_pkg::grp_pin_wr, cmd_pkg::grp_ureg_wr: begin
              if (idx_ok) begin
                state <= cmd_pkg::st_data;
              end
            end
            cmd_pkg::grp_pin_rel: begin
              if (idx_ok) begin
                out_oe[sel] <= 1'b0;     // pin value kept
              end
            end
            cmd_pkg::grp_mem: begin
              if (cmd.raw == cmd_pkg::op_mem_wr || cmd.raw == cmd_pkg::op_mem_rd ||
                  cmd.raw == cmd_pkg::op_burst_rd) begin
                mem.cyc   <= 1'b1;
                mem.stb   <= 1'b1;
                mem.we    <= cmd.raw == cmd_pkg::op_mem_wr;
                mem.adr   <= ureg[2];
                mem.dat_w <= {ureg[1], ureg[0]};
                wcnt      <= '0;
                sum       <= '0;
                state     <= (cmd.raw == cmd_pkg::op_burst_rd) ? cmd_pkg::st_bmem
                                                                : cmd_pkg::st_mem;
              end
            end
            default: ;
          endcase
        end

        cmd_pkg::st_data: begin
          if (rx_valid) begin
            if (cmd.f.grp == cmd_pkg::grp_pin_wr) begin
              out_pins[sel] <= rx_data;
              out_oe[sel]   <= 1'b1;
            end else begin
              ureg[sel] <= rx_data;
            end
            state <= cmd_pkg::st_idle;
          end
        end

        cmd_pkg::st_send: begin
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_data  <= (cmd.f.grp == cmd_pkg::grp_pin_rd) ? in_pins[sel] : res[sel];
            state    <= cmd_pkg::st_idle;
          end
        end

        cmd_pkg::st_mem: begin
          if (mem.ack) begin
            mem.cyc <= 1'b0;
            mem.stb <= 1'b0;
            if (cmd.raw == cmd_pkg::op_mem_rd) begin
              res[1] <= mem.dat_r[cmd_pkg::mem_dw-1:cmd_pkg::byte_w];
              res[0] <= mem.dat_r[cmd_pkg::byte_w-1:0];
            end
            state <= cmd_pkg::st_idle;
          end
        end

        cmd_pkg::st_bmem: begin
          if (mem.ack) begin
            mem.cyc  <= 1'b0;
            mem.stb  <= 1'b0;
            word_buf <= mem.dat_r;
            hi_byte  <= 1'b0;
            state    <= cmd_pkg::st_btx;
          end
        end

        // low byte first, then high byte, then fetch the next word
        cmd_pkg::st_btx: begin
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_data  <= burst_byte;
            sum      <= sum + burst_byte;
            hi_byte  <= 1'b1;
            if (hi_byte) begin
              if (wcnt == cmd_pkg::burst_words - 1) begin
                state <= cmd_pkg::st_bsum;
              end else begin
                wcnt    <= wcnt + 1'b1;
                mem.adr <= mem.adr + 1'b1;   // wraps at 256
                mem.cyc <= 1'b1;
                mem.stb <= 1'b1;
                state   <= cmd_pkg::st_bmem;
              end
            end
          end
        end

        cmd_pkg::st_bsum: begin
          if (tx_ready) begin
            tx_start <= 1'b1;
            tx_data  <= sum;
            state    <= cmd_pkg::st_idle;
          end
        end

        default: state <= cmd_pkg::st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== word_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_ram (
  input wire  sys_clk,
  input wire  sys_rst_n,
  wb_if.slave bus
);

  logic [cmd_pkg::mem_dw-1:0] mem [2**cmd_pkg::mem_aw] = '{default: '0};

  // ack one cycle after stb, stays up one cycle after stb drops
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.cyc && bus.stb;
    end
  end

  // write lands on the acknowledged edge
  always_ff @(posedge sys_clk) begin
    if (bus.cyc && bus.stb && bus.we && bus.ack) begin
      mem[bus.adr] <= bus.dat_w;
    end
    bus.dat_r <= mem[bus.adr];           // adr is held, so valid during ack
  end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  wire                         sys_clk,
  input  wire                         sys_rst_n,
  input  wire                         tx_start,
  input  wire  [cmd_pkg::byte_w-1:0]  tx_data,
  output logic                        uart_txd,
  output logic                        tx_busy
);

  logic [cmd_pkg::byte_w:0]                 frame;    // data bits, then stop bit on top
  logic [$clog2(cmd_pkg::clks_per_bit)-1:0] cnt;
  logic [3:0]                               bitn;     // bit on the line, 0 start .. 9 stop
  logic                                     bit_end;

  assign bit_end = tx_busy && cnt == cmd_pkg::clks_per_bit - 1;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      uart_txd <= 1'b1;                  // line idles high
      tx_busy  <= 1'b0;
      cnt      <= '0;
      bitn     <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        tx_busy  <= 1'b1;
        uart_txd <= 1'b0;                // start bit
        cnt      <= '0;
        bitn     <= '0;
      end
    end else if (bit_end) begin
      cnt <= '0;
      if (bitn == 4'd9) begin
        tx_busy  <= 1'b0;                // stop bit done
        uart_txd <= 1'b1;
      end else begin
        bitn     <= bitn + 1'b1;
        uart_txd <= frame[0];
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!tx_busy && tx_start) begin
      frame <= {1'b1, tx_data};
    end else if (bit_end) begin
      frame <= {1'b1, frame[cmd_pkg::byte_w:1]};
    end
  end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  wire                         sys_clk,
  input  wire                         sys_rst_n,
  input  wire                         uart_rxd,
  output logic                        rx_valid,
  output logic [cmd_pkg::byte_w-1:0]  rx_data
);

  logic [1:0]                               rxd_sync;
  logic                                     rxd;
  logic                                     active;     // inside a frame
  logic [$clog2(cmd_pkg::clks_per_bit)-1:0] cnt;
  logic [3:0]                               bitn;       // 0 start, 1..8 data, 9 stop, 10 tail
  logic                                     full_tick;
  logic                                     half_tick;

  assign rxd       = rxd_sync[1];
  assign full_tick = cnt == cmd_pkg::clks_per_bit - 1;
  assign half_tick = cnt == cmd_pkg::clks_per_bit / 2 - 1;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_sync <= 2'b11;
      active   <= 1'b0;
      cnt      <= '0;
      bitn     <= '0;
      rx_valid <= 1'b0;
    end else begin
      rxd_sync <= {rxd_sync[0], uart_rxd};
      rx_valid <= 1'b0;
      if (!active) begin
        cnt  <= '0;
        bitn <= '0;
        if (!rxd) begin
          active <= 1'b1;                // falling edge, possible start bit
        end
      end else begin
        cnt <= cnt + 1'b1;
        if (bitn == 4'd0) begin
          // middle of start bit, must still be low
          if (half_tick) begin
            cnt <= '0;
            if (rxd) begin
              active <= 1'b0;            // glitch
            end else begin
              bitn <= 4'd1;
            end
          end
        end else if (bitn <= 4'd8) begin
          if (full_tick) begin
            cnt  <= '0;
            bitn <= bitn + 1'b1;
          end
        end else if (bitn == 4'd9) begin
          if (full_tick) begin
            cnt <= '0;
            if (rxd) begin
              bitn <= 4'd10;
            end else begin
              active <= 1'b0;            // framing error, frame dropped
            end
          end
        end else if (half_tick) begin
          rx_valid <= 1'b1;
          active   <= 1'b0;
        end
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge sys_clk) begin
    if (active && full_tick && bitn >= 4'd1 && bitn <= 4'd8) begin
      rx_data <= {rxd, rx_data[cmd_pkg::byte_w-1:1]};
    end
  end

endmodule

`default_nettype wire

// ==== wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_if;

  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [cmd_pkg::mem_aw-1:0] adr;
  logic [cmd_pkg::mem_dw-1:0] dat_w;
  logic [cmd_pkg::mem_dw-1:0] dat_r;
  logic                       ack;

  // classic single-word cycles, no pipelining
  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// ==== cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

  // datapath widths
  localparam int byte_w  = 8;
  localparam int n_ports = 8;
  localparam int n_uregs = 8;
  localparam int sel_w   = $clog2(n_ports);   // port / register index bits
  localparam int mem_aw  = 8;                  // 256 words
  localparam int mem_dw  = 16;

  // uart and burst timing
  localparam int clks_per_bit = 16;            // sys_clk cycles per bit
  localparam int burst_words  = 8;

  // command groups, high nibble of the command byte
  localparam logic [3:0] grp_ctrl    = 4'h1;
  localparam logic [3:0] grp_pin_rd  = 4'h2;
  localparam logic [3:0] grp_pin_wr  = 4'h3;
  localparam logic [3:0] grp_ureg_wr = 4'h4;
  localparam logic [3:0] grp_res_rd  = 4'h5;
  localparam logic [3:0] grp_pin_rel = 4'h6;
  localparam logic [3:0] grp_mem     = 4'hA;

  // full memory opcodes
  localparam logic [byte_w-1:0] op_mem_wr   = 8'hA0;
  localparam logic [byte_w-1:0] op_mem_rd   = 8'hA1;
  localparam logic [byte_w-1:0] op_burst_rd = 8'hA3;

  // executor FSM states
  localparam logic [2:0] st_idle = 3'd0;
  localparam logic [2:0] st_exec = 3'd1;
  localparam logic [2:0] st_data = 3'd2;    // waiting for the data byte
  localparam logic [2:0] st_send = 3'd3;
  localparam logic [2:0] st_mem  = 3'd4;
  localparam logic [2:0] st_bmem = 3'd5;    // burst word fetch
  localparam logic [2:0] st_btx  = 3'd6;    // burst byte send
  localparam logic [2:0] st_bsum = 3'd7;    // burst checksum

  // command byte, seen whole or as group + index
  typedef union packed {
    logic [byte_w-1:0] raw;
    struct packed {
      logic [3:0] grp;
      logic [3:0] idx;
    } f;
  } cmd_t;

endpackage

`default_nettype wire
